//--- include/eth_tx_defines.svh
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// header lengths in bytes.
`define UDP_HDR_LEN  8
`define IPV4_HDR_LEN 20

// payload buffer depth and its address width.
`define PLD_MAX      64
`define PLD_AW       6

`define IP_TTL       128
`define IP_PROTO_UDP 17 // protocol number of UDP.

`endif

//--- logic/eth_tx_pkg.sv
package eth_tx_pkg;

  typedef logic [7:0] byte_t;

  typedef logic [3:0][7:0] ipv4_addr_t; // byte 3 goes out first.

  typedef logic [5:0][7:0] mac_addr_t;

  typedef logic [15:0] port_t;

  // fields are in network order, so the first field sits in the top bits.
  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    logic [15:0] length;   // header plus payload.
    logic [15:0] chksum;
  } udp_hdr_t;

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;
    logic [15:0] id;
    logic        rsv;      // the reserved flag bit keeps the header at 20 bytes.
    logic        df;
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chksum;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
  } ipv4_hdr_t;

  // what the UDP layer is handed along with the datagram.
  typedef struct packed {
    udp_hdr_t    udp_hdr;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
    logic [15:0] id;
    mac_addr_t   dst_mac;
    logic        mac_known;
  } udp_meta_t;

  typedef struct packed {
    ipv4_hdr_t   ipv4_hdr;
    logic [15:0] pld_len;  // length of the IP payload, which is the whole UDP datagram.
    mac_addr_t   dst_mac;
    logic        mac_known;
  } ipv4_meta_t;

endpackage

//--- logic/hdr_stream_if.sv
`timescale 1ns/1ps

interface hdr_stream_if #(
  parameter type meta_t = logic
) ();

  logic              rdy; // packet waiting with meta stable.
  logic              req; // sink wants bytes until eof.
  meta_t             meta;
  logic              val;
  logic              sof;
  logic              eof;
  eth_tx_pkg::byte_t dat;

  modport src (
    output rdy, meta, val, sof, eof, dat,
    input  req
  );

  modport snk (
    input  rdy, meta, val, sof, eof, dat,
    output req
  );

endinterface

//--- logic/udp_pld_buf.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module udp_pld_buf (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  eth_tx_pkg::port_t      src_port,
  input  eth_tx_pkg::port_t      dst_port,
  input  eth_tx_pkg::ipv4_addr_t dst_ip,
  input  logic [15:0]            ip_id,
  input  eth_tx_pkg::mac_addr_t  dst_mac,
  input  logic                   mac_known,
  input  logic                   pld_val,
  input  logic                   pld_last,
  input  eth_tx_pkg::byte_t      pld_dat,
  output logic                   pld_busy,
  hdr_stream_if.src              udp
);

  eth_tx_pkg::byte_t  mem [`PLD_MAX];
  logic [`PLD_AW:0]   wr_cnt;  // one bit wider so a full buffer counts to PLD_MAX.
  logic [`PLD_AW-1:0] rd_ptr;
  logic               wr_en;
  logic               rd_en;
  logic               last_rd;

  assign wr_en   = pld_val && !pld_busy; // writes are refused while a datagram waits.
  assign rd_en   = udp.rdy && udp.req;
  assign last_rd = ({1'b0, rd_ptr} == wr_cnt - 1'b1);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_cnt[`PLD_AW-1:0]] <= pld_dat; // datagrams beyond PLD_MAX bytes are not supported.
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_cnt   <= '0;
      rd_ptr   <= '0;
      pld_busy <= 1'b0;
      udp.rdy  <= 1'b0;
    end
    else if (udp.eof) begin
      wr_cnt   <= '0; // the buffer is free again one cycle after the last byte.
      rd_ptr   <= '0;
      pld_busy <= 1'b0;
      udp.rdy  <= 1'b0;
    end
    else begin
      if (wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (pld_last) pld_busy <= 1'b1;
      end
      if (pld_busy) udp.rdy <= 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // addressing is captured together with the last payload byte.
  always_ff @(posedge clk) begin
    if (wr_en && pld_last) begin
      udp.meta.udp_hdr.src_port <= src_port;
      udp.meta.udp_hdr.dst_port <= dst_port;
      udp.meta.udp_hdr.length   <= 16'(wr_cnt) + 16'd1 + 16'(`UDP_HDR_LEN);
      udp.meta.udp_hdr.chksum   <= '0; // a zero UDP checksum means none was computed.
      udp.meta.src_ip           <= '0; // the header stage fills in the device address.
      udp.meta.dst_ip           <= dst_ip;
      udp.meta.id               <= ip_id;
      udp.meta.dst_mac          <= dst_mac;
      udp.meta.mac_known        <= mac_known;
    end
  end

  assign udp.val = rd_en;
  assign udp.sof = rd_en && (rd_ptr == '0);
  assign udp.eof = rd_en && last_rd;
  assign udp.dat = mem[rd_ptr];

endmodule

//--- logic/udp_hdr_tx.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module udp_hdr_tx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  eth_tx_pkg::ipv4_addr_t dev_ip,
  hdr_stream_if.snk              udp,
  hdr_stream_if.src              ip
);

  logic [`UDP_HDR_LEN-1:0][7:0] hdr;
  eth_tx_pkg::byte_t            hdr_tx;
  logic [15:0]                  byte_cnt;
  logic                         rst_int;

  // the block restarts by itself once the packet has gone out.
  assign rst_int = fsm_rst || ip.eof;

  always_ff @(posedge clk) begin
    if (rst_int) begin
      ip.rdy   <= 1'b0;
      ip.val   <= 1'b0;
      udp.req  <= 1'b0;
      byte_cnt <= '0;
    end
    else begin
      if (ip.val) byte_cnt <= byte_cnt + 1'b1;
      if (udp.rdy && !ip.rdy) begin
        ip.rdy <= 1'b1;
      end
      else if (ip.req && ip.rdy) begin
        ip.val <= 1'b1;
        // the first payload byte then lands right after the last header byte.
        if (ip.val && byte_cnt == `UDP_HDR_LEN-1) udp.req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    hdr_tx <= hdr[`UDP_HDR_LEN-1];
    if (udp.rdy && !ip.rdy) begin
      hdr                         <= udp.meta.udp_hdr;
      ip.meta.pld_len             <= udp.meta.udp_hdr.length;
      ip.meta.dst_mac             <= udp.meta.dst_mac;
      ip.meta.mac_known           <= udp.meta.mac_known;
      ip.meta.ipv4_hdr.ver        <= 4'd4;
      ip.meta.ipv4_hdr.ihl        <= 4'd5; // no options.
      ip.meta.ipv4_hdr.qos        <= '0;
      ip.meta.ipv4_hdr.length     <= udp.meta.udp_hdr.length + 16'(`IPV4_HDR_LEN);
      ip.meta.ipv4_hdr.id         <= udp.meta.id;
      ip.meta.ipv4_hdr.rsv        <= 1'b0;
      ip.meta.ipv4_hdr.df         <= 1'b0;
      ip.meta.ipv4_hdr.mf         <= 1'b0;
      ip.meta.ipv4_hdr.fo         <= '0;
      ip.meta.ipv4_hdr.ttl        <= 8'(`IP_TTL);
      ip.meta.ipv4_hdr.proto      <= 8'(`IP_PROTO_UDP);
      ip.meta.ipv4_hdr.chksum     <= '0;   // computed in the IPv4 stage.
      ip.meta.ipv4_hdr.src_ip     <= dev_ip;
      ip.meta.ipv4_hdr.dst_ip     <= udp.meta.dst_ip;
    end
    else if (ip.req && ip.rdy) begin
      hdr[`UDP_HDR_LEN-1:1] <= hdr[`UDP_HDR_LEN-2:0];
    end
  end

  assign ip.sof = ip.val && (byte_cnt == '0);
  assign ip.eof = ip.val && udp.eof;
  assign ip.dat = udp.req ? udp.dat : hdr_tx; // payload follows once upstream is requested.

endmodule

//--- logic/ipv4_hdr_tx.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module ipv4_hdr_tx (
  input  logic                  clk,
  input  logic                  fsm_rst,
  hdr_stream_if.snk             ip,
  input  logic                  pkt_req,
  output logic                  pkt_rdy,
  output eth_tx_pkg::mac_addr_t pkt_dst_mac,
  output logic                  pkt_mac_known,
  output logic                  pkt_val,
  output logic                  pkt_sof,
  output logic                  pkt_eof,
  output eth_tx_pkg::byte_t     pkt_dat
);

  logic [`IPV4_HDR_LEN-1:0][7:0] hdr;
  eth_tx_pkg::ipv4_hdr_t         hdr_nochk;
  eth_tx_pkg::ipv4_hdr_t         hdr_ld;
  logic [4:0]                    hcnt;
  logic                          active; // header bytes are being sent.
  logic                          fwd;    // the UDP stream is being forwarded.
  logic                          load;

  // ones' complement of the ones' complement sum of the ten header words.
  function automatic logic [15:0] hdr_chksum(input eth_tx_pkg::ipv4_hdr_t h);
    logic [9:0][15:0] w;
    logic [19:0]      sum;
    w   = h;
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 20'(w[i]);
    end
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]); // a second fold absorbs the last carry.
    return ~sum[15:0];
  endfunction

  always_comb begin
    hdr_nochk        = ip.meta.ipv4_hdr;
    hdr_nochk.chksum = '0;
    hdr_ld           = hdr_nochk;
    hdr_ld.chksum    = hdr_chksum(hdr_nochk);
  end

  assign load = ip.rdy && !pkt_rdy;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pkt_rdy <= 1'b0;
      active  <= 1'b0;
      fwd     <= 1'b0;
      hcnt    <= '0;
      ip.req  <= 1'b0;
      pkt_val <= 1'b0;
      pkt_sof <= 1'b0;
      pkt_eof <= 1'b0;
    end
    else if (pkt_val && pkt_eof) begin
      pkt_rdy <= 1'b0; // the last byte is out, so get ready for the next packet.
      active  <= 1'b0;
      fwd     <= 1'b0;
      hcnt    <= '0;
      ip.req  <= 1'b0;
      pkt_val <= 1'b0;
      pkt_sof <= 1'b0;
      pkt_eof <= 1'b0;
    end
    else begin
      if (load) begin
        pkt_rdy <= 1'b1;
      end
      else if (pkt_req && pkt_rdy && !active) begin
        active <= 1'b1;
      end
      if (active && !fwd) begin
        pkt_val <= 1'b1;
        pkt_sof <= (hcnt == '0);
        hcnt    <= hcnt + 1'b1;
        // upstream needs two cycles from req to its first byte on our output.
        if (hcnt == `IPV4_HDR_LEN-2) ip.req <= 1'b1;
        if (hcnt == `IPV4_HDR_LEN-1) fwd <= 1'b1;
      end
      else if (fwd) begin
        pkt_val <= ip.val;
        pkt_sof <= 1'b0;
        pkt_eof <= ip.eof;
        if (ip.eof) ip.req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hdr           <= hdr_ld;
      pkt_dst_mac   <= ip.meta.dst_mac;
      pkt_mac_known <= ip.meta.mac_known;
    end
    else if (active && !fwd) begin
      hdr[`IPV4_HDR_LEN-1:1] <= hdr[`IPV4_HDR_LEN-2:0];
    end
    pkt_dat <= fwd ? ip.dat : hdr[`IPV4_HDR_LEN-1];
  end

endmodule

//--- logic/udp_ipv4_tx_top.sv
`timescale 1ns/1ps

module udp_ipv4_tx_top (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  eth_tx_pkg::ipv4_addr_t dev_ip,
  input  eth_tx_pkg::port_t      src_port,
  input  eth_tx_pkg::port_t      dst_port,
  input  eth_tx_pkg::ipv4_addr_t dst_ip,
  input  logic [15:0]            ip_id,
  input  eth_tx_pkg::mac_addr_t  dst_mac,
  input  logic                   mac_known,
  input  logic                   pld_val,
  input  eth_tx_pkg::byte_t      pld_dat,
  input  logic                   pld_last,
  input  logic                   pkt_req,
  output logic                   pld_busy,
  output logic                   pkt_rdy,
  output eth_tx_pkg::mac_addr_t  pkt_dst_mac,
  output logic                   pkt_mac_known,
  output logic                   pkt_val,
  output logic                   pkt_sof,
  output logic                   pkt_eof,
  output eth_tx_pkg::byte_t      pkt_dat
);

  hdr_stream_if #(.meta_t(eth_tx_pkg::udp_meta_t))  udp_if ();
  hdr_stream_if #(.meta_t(eth_tx_pkg::ipv4_meta_t)) ip_if ();

  udp_pld_buf u_pld_buf (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .src_port  (src_port),
    .dst_port  (dst_port),
    .dst_ip    (dst_ip),
    .ip_id     (ip_id),
    .dst_mac   (dst_mac),
    .mac_known (mac_known),
    .pld_val   (pld_val),
    .pld_last  (pld_last),
    .pld_dat   (pld_dat),
    .pld_busy  (pld_busy),
    .udp       (udp_if.src)
  );

  udp_hdr_tx u_udp_hdr_tx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dev_ip  (dev_ip),
    .udp     (udp_if.snk),
    .ip      (ip_if.src)
  );

  ipv4_hdr_tx u_ipv4_hdr_tx (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .ip            (ip_if.snk),
    .pkt_req       (pkt_req),
    .pkt_rdy       (pkt_rdy),
    .pkt_dst_mac   (pkt_dst_mac),
    .pkt_mac_known (pkt_mac_known),
    .pkt_val       (pkt_val),
    .pkt_sof       (pkt_sof),
    .pkt_eof       (pkt_eof),
    .pkt_dat       (pkt_dat)
  );

endmodule

//--- sim/tb_udp_ipv4_tx.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module tb_udp_ipv4_tx;

  localparam eth_tx_pkg::ipv4_addr_t dev_addr = 32'hc0a8_0164;

  logic                   clk = 1'b0;
  logic                   fsm_rst;
  eth_tx_pkg::ipv4_addr_t dev_ip, dst_ip;
  eth_tx_pkg::port_t      src_port, dst_port;
  logic [15:0]            ip_id;
  eth_tx_pkg::mac_addr_t  dst_mac, pkt_dst_mac;
  logic                   mac_known, pld_val, pld_last, pkt_req;
  eth_tx_pkg::byte_t      pld_dat, pkt_dat;
  logic                   pld_busy, pkt_rdy, pkt_mac_known, pkt_val, pkt_sof, pkt_eof;

  logic [47:0]       pat_mem [0:511];
  int                rec_ofs [0:15];
  int                n_rec;
  longint            wdog_cycles = 0;
  int                err_cnt = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  eth_tx_pkg::byte_t exp_q [$];
  eth_tx_pkg::byte_t got_q [$];

  always #20 clk = ~clk;

  udp_ipv4_tx_top dut (.*);

  task automatic check_byte(input string name, input eth_tx_pkg::byte_t exp,
                            input eth_tx_pkg::byte_t act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %02h, got %02h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_mac(input string name, input eth_tx_pkg::mac_addr_t exp,
                           input eth_tx_pkg::mac_addr_t act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string what, input int err_start);
    if (err_cnt == err_start) begin
      pass_cnt++;
      $display("%s: pass", what);
    end
    else begin
      fail_cnt++;
      $display("%s: FAIL with %0d errors", what, err_cnt - err_start);
    end
  endtask

  // ones' complement sum of the ten header words, checksum field taken as zero.
  function automatic logic [15:0] ipv4_chksum(input logic [15:0] tl, input logic [15:0] id,
                                              input logic [31:0] dip);
    logic [31:0] src;
    logic [31:0] sum;
    src = dev_addr;
    sum = 32'h4500 + tl + id + {16'h0, 8'(`IP_TTL), 8'(`IP_PROTO_UDP)};
    sum = sum + src[31:16] + src[15:0] + dip[31:16] + dip[15:0];
    while (sum[31:16] != 16'h0) sum = sum[15:0] + sum[31:16];
    return ~sum[15:0];
  endfunction

  task automatic build_expected(input int ofs);
    int                 len;
    logic [15:0]        tl;
    logic [15:0]        ck;
    logic [27:0][7:0]   hdr;
    len = int'(pat_mem[ofs+6][15:0]);
    tl  = 16'(len + `IPV4_HDR_LEN + `UDP_HDR_LEN);
    ck  = ipv4_chksum(tl, pat_mem[ofs+3][15:0], pat_mem[ofs+2][31:0]);
    hdr = {8'h45, 8'h00, tl, pat_mem[ofs+3][15:0], 16'h0000, 8'(`IP_TTL),
           8'(`IP_PROTO_UDP), ck, dev_addr, pat_mem[ofs+2][31:0], pat_mem[ofs][15:0],
           pat_mem[ofs+1][15:0], 16'(len + `UDP_HDR_LEN), 16'h0000};
    exp_q = {};
    for (int i = 27; i >= 0; i--) exp_q.push_back(hdr[i]);
    for (int i = 0; i < len; i++) exp_q.push_back(pat_mem[ofs+9+i][7:0]);
  endtask

  task automatic run_record(input int r);
    int ofs, len, delay, err_start;
    bit done;
    ofs       = rec_ofs[r];
    len       = int'(pat_mem[ofs+6][15:0]);
    delay     = int'(pat_mem[ofs+7][15:0]);
    err_start = err_cnt;
    build_expected(ofs);
    while (pld_busy) @(posedge clk);
    src_port  <= pat_mem[ofs][15:0];
    dst_port  <= pat_mem[ofs+1][15:0];
    dst_ip    <= pat_mem[ofs+2][31:0];
    ip_id     <= pat_mem[ofs+3][15:0];
    dst_mac   <= pat_mem[ofs+4];
    mac_known <= pat_mem[ofs+5][0];
    for (int i = 0; i < len; i++) begin
      if ($urandom % 8 == 0) begin
        pld_val <= 1'b0;
        @(posedge clk);
      end
      pld_val  <= 1'b1;
      pld_dat  <= pat_mem[ofs+9+i][7:0];
      pld_last <= (i == len - 1);
      @(posedge clk);
    end
    // these writes land while the buffer is busy and must be dropped.
    for (int j = 0; j < 3; j++) begin
      pld_val  <= 1'b1;
      pld_last <= 1'b1;
      pld_dat  <= 8'ha5 + 8'(j);
      src_port <= ~pat_mem[ofs][15:0];
      dst_mac  <= ~pat_mem[ofs+4];
      @(posedge clk);
    end
    pld_val  <= 1'b0;
    pld_last <= 1'b0;
    while (!pkt_rdy) @(posedge clk);
    check_mac("pkt_dst_mac", pat_mem[ofs+4], pkt_dst_mac);
    check_bit("pkt_mac_known", pat_mem[ofs+5][0], pkt_mac_known);
    repeat (delay) begin
      @(posedge clk);
      check_bit("pkt_rdy", 1'b1, pkt_rdy);
      check_bit("pkt_val", 1'b0, pkt_val);
      check_bit("pld_busy", 1'b1, pld_busy);
    end
    pkt_req <= 1'b1;
    got_q = {};
    done  = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (pkt_val) begin
        check_bit("pkt_sof", got_q.size() == 0, pkt_sof);
        check_bit("pkt_eof", got_q.size() == exp_q.size() - 1, pkt_eof);
        got_q.push_back(pkt_dat);
        done = pkt_eof || (got_q.size() >= exp_q.size());
      end
      else if (got_q.size() != 0) begin
        $display("ERROR at %0t ns: pkt_val dropped after %0d bytes", $time, got_q.size());
        err_cnt++;
      end
    end
    pkt_req <= 1'b0;
    if (got_q.size() != exp_q.size()) begin
      $display("ERROR: packet %0d ended after %0d bytes instead of %0d",
               r + 1, got_q.size(), exp_q.size());
      err_cnt++;
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check_byte($sformatf("pkt_dat[%0d]", i), exp_q[i], got_q[i]);
    end
    if (got_q.size() > 11) begin
      check_byte("pkt_dat[10] vs pattern chksum", pat_mem[ofs+8][15:8], got_q[10]);
      check_byte("pkt_dat[11] vs pattern chksum", pat_mem[ofs+8][7:0], got_q[11]);
    end
    report_test($sformatf("test %0d: %0d payload bytes, request delay %0d", r + 1, len, delay),
                err_start);
  endtask

  initial begin
    int          ofs;
    longint      limit;
    int          err_start;
    fsm_rst   <= 1'b1;
    dev_ip    <= dev_addr;
    src_port  <= '0;
    dst_port  <= '0;
    dst_ip    <= '0;
    ip_id     <= '0;
    dst_mac   <= '0;
    mac_known <= 1'b0;
    pld_val   <= 1'b0;
    pld_dat   <= '0;
    pld_last  <= 1'b0;
    pkt_req   <= 1'b0;
    void'($urandom(32'heb2e_7976));
    $readmemh("sim/udp_tx_patterns.txt", pat_mem);
    n_rec = int'(pat_mem[0][15:0]);
    ofs   = 1;
    limit = 0;
    for (int r = 0; r < n_rec; r++) begin
      rec_ofs[r] = ofs;
      limit += int'(pat_mem[ofs+6][15:0]) + `UDP_HDR_LEN + `IPV4_HDR_LEN
               + int'(pat_mem[ofs+7][15:0]) + 40;
      ofs += 9 + int'(pat_mem[ofs+6][15:0]);
    end
    repeat (8) @(posedge clk);
    fsm_rst <= 1'b0;
    wdog_cycles = limit; // the watchdog starts once reset is released.
    @(posedge clk);
    err_start = err_cnt;
    check_bit("pld_busy", 1'b0, pld_busy);
    check_bit("pkt_rdy", 1'b0, pkt_rdy);
    check_bit("pkt_val", 1'b0, pkt_val);
    report_test("reset values", err_start);
    for (int r = 0; r < n_rec; r++) run_record(r);
    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Everything OK");
    end
    else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (wdog_cycles > 0);
    #(wdog_cycles * 40);
    $display("the run timed out after %0d cycles without finishing", wdog_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

//--- sim/udp_tx_patterns.txt
// record count, then per record: src_port dst_port dst_ip ip_id dst_mac mac_known
// payload_len req_delay ipv4_chksum, followed by payload_len payload bytes
0004
04D2 162E C0A8010A 0001 02000000000A 1 0001 0000 B710
7E
0400 0035 0A000001 BEEF 001B213C4D5E 1 0005 0006 AFCF
48 65 6C 6C 6F
C000 FFFF FFFFFFFF FFFF FFFFFFFFFFFF 0 0040 0003 7885
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
8000 0007 AC102A07 0100 3C970E112233 1 0011 0001 A19C
DE AD BE EF 00 11 22 33 44 55 66 77 88 99 AA BB
CC

//--- tb.f
+incdir+include
logic/eth_tx_pkg.sv
logic/hdr_stream_if.sv
logic/udp_pld_buf.sv
logic/udp_hdr_tx.sv
logic/ipv4_hdr_tx.sv
logic/udp_ipv4_tx_top.sv
sim/tb_udp_ipv4_tx.sv

//--- Bender.yml
package:
  name: udp_ipv4_tx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/eth_tx_pkg.sv
      - logic/hdr_stream_if.sv
      - logic/udp_pld_buf.sv
      - logic/udp_hdr_tx.sv
      - logic/ipv4_hdr_tx.sv
      - logic/udp_ipv4_tx_top.sv
      - target: simulation
        files:
          - sim/tb_udp_ipv4_tx.sv
